// ==== src.f ====
+incdir+logic
logic/clmul_types_pkg.sv
logic/clmul_ctrl_pkg.sv
logic/karatsuba_ctrl.sv
logic/bit_counter.sv
logic/clmul_serial.sv
logic/karatsuba_combine.sv
logic/karatsuba_top.sv
sim/karatsuba_asserts.sv
sim/karatsuba_checker.sv
sim/tb_karatsuba.sv

// ==== Makefile ====
# Verilator build and run for the Karatsuba carry-less multiplier

VERILATOR ?= verilator
TOP       ?= tb_karatsuba
BUILD_DIR ?= build
LOG       ?= sim.log
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF 'All tests passed!' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/tb_karatsuba.sv ====
// Testbench for the Karatsuba carry-less multiplier
// Operands come from a 32-bit LCG with a fixed seed
// karatsuba_checker compares the products
// Inputs change 5 ns after each rising edge
`default_nettype none

`include "clmul_params.svh"

module tb_karatsuba;

	timeunit 1ns;
	timeprecision 1ps;

	import clmul_types_pkg::*;

	localparam int WAIT_LIMIT = 200;
	localparam int RANDOM_OPS = 200;

	logic     clk;
	logic     rst;
	logic     req;
	operand_t a;
	operand_t b;
	logic     ack;
	product_t product;

	logic [31:0] rng_state;
	int          ops_done;
	int          tb_errors;
	int          timeouts;

	karatsuba_top karatsuba_top_inst (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.a       (a),
		.b       (b),
		.ack     (ack),
		.product (product)
	);

	karatsuba_checker karatsuba_checker_inst (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.ack     (ack),
		.a       (a),
		.b       (b),
		.product (product)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// Classic 32-bit LCG step
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic operand_t rand_operand();
		operand_t v;
		v = '0;
		for (int k = 0; k < (`CLMUL_OPERAND_W + 31) / 32; k++) begin
			v = (v << 32) | operand_t'(next_rand());
		end
		return v;
	endfunction

	// Move to the drive point just after the next rising edge
	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (ack !== level) begin
			$display("timeout at %0t: ack did not go %s within %0d cycles",
				$time, level ? "high" : "low", WAIT_LIMIT);
			timeouts++;
		end
	endtask

	// One full four-phase handshake with req held for hold extra cycles past ack
	task automatic run_op(input operand_t a_val, input operand_t b_val,
			input int hold, input int gap);
		a   = a_val;
		b   = b_val;
		req = 1'b1;
		wait_ack(1'b1);
		repeat (hold) next_cycle();
		req = 1'b0;
		wait_ack(1'b0);
		ops_done++;
		repeat (gap) next_cycle();
	endtask

	initial begin
		operand_t opa;
		operand_t opb;
		half_t    h;
		half_t    g;
		int       i;
		int       j;
		int       hold;
		int       gap;

		rng_state = 32'hebe7;
		ops_done  = 0;
		tb_errors = 0;
		timeouts  = 0;
		rst       = 1'b1;
		req       = 1'b0;
		a         = '0;
		b         = '0;
		repeat (16) @(posedge clk);
		#5;
		rst = 1'b0;
		next_cycle();
		if (ack !== 1'b0) begin
			$display("mismatch at %0t: ack %b after reset, expected 0", $time, ack);
			tb_errors++;
		end

		for (int n = 0; n < RANDOM_OPS; n++) begin
			opa = rand_operand();
			opb = rand_operand();
			run_op(opa, opb, 0, 0);
		end

		// Corner operands
		opb = rand_operand();
		run_op('0, opb, 0, 0);
		run_op(opb, '0, 0, 0);
		run_op('1, '1, 0, 0);
		for (int k = 0; k < 4; k++) begin
			i = int'(next_rand() % `CLMUL_HALF_W);
			j = `CLMUL_HALF_W + int'(next_rand() % `CLMUL_HALF_W);
			run_op(operand_t'(1) << i, operand_t'(1) << j, 0, 0);
			// A single product bit at i + j
			if (product !== (product_t'(1) << (i + j))) begin
				$display("mismatch at %0t: bits %0d and %0d gave %h", $time, i, j, product);
				tb_errors++;
			end
			run_op(operand_t'(1) << j, operand_t'(1) << i, 0, 0);
		end
		// Equal halves make the middle sums zero
		for (int k = 0; k < 4; k++) begin
			opa = rand_operand();
			opb = rand_operand();
			h   = half_t'(opa);
			g   = half_t'(opb);
			run_op({h, h}, {g, g}, 0, 0);
		end

		// Back-pressure and idle gaps
		for (int k = 0; k < 20; k++) begin
			opa  = rand_operand();
			opb  = rand_operand();
			hold = int'(next_rand() % 21);
			gap  = int'(next_rand() % 8);
			run_op(opa, opb, hold, gap);
		end

		// Reset partway through a run
		a   = rand_operand();
		b   = rand_operand();
		req = 1'b1;
		repeat (40) next_cycle();
		rst = 1'b1;
		req = 1'b0;
		repeat (4) next_cycle();
		rst = 1'b0;
		if (ack !== 1'b0) begin
			$display("mismatch at %0t: ack %b after reset during a run, expected 0",
				$time, ack);
			tb_errors++;
		end
		// Reset clears the product still held from the previous operation
		if (product !== '0) begin
			$display("mismatch at %0t: product %h after reset during a run, expected 0",
				$time, product);
			tb_errors++;
		end
		opa = rand_operand();
		opb = rand_operand();
		run_op(opa, opb, 2, 0);

		if (karatsuba_checker_inst.test_count != ops_done) begin
			$display("error: %0d products checked but %0d operations completed",
				karatsuba_checker_inst.test_count, ops_done);
			tb_errors++;
		end
		$display("tests: %0d, checker errors: %0d, testbench errors: %0d, timeouts: %0d",
			karatsuba_checker_inst.test_count, karatsuba_checker_inst.error_count,
			tb_errors, timeouts);
		if (karatsuba_checker_inst.error_count == 0 && tb_errors == 0 && timeouts == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim/karatsuba_checker.sv ====
// Watches the handshake and compares each product with a schoolbook carry-less multiply
// Operands are taken when req is first seen high, the result when ack is first seen high
`default_nettype none

`include "clmul_params.svh"

module karatsuba_checker (
	input logic                      clk,
	input logic                      rst,
	input logic                      req,
	input logic                      ack,
	input clmul_types_pkg::operand_t a,
	input clmul_types_pkg::operand_t b,
	input clmul_types_pkg::product_t product
);

	timeunit 1ns;
	timeprecision 1ps;

	import clmul_types_pkg::*;

	logic     req_q = 1'b0;
	logic     ack_q = 1'b0;
	logic     pending = 1'b0;
	logic     holding = 1'b0;
	operand_t a_seen;
	operand_t b_seen;
	product_t expected;
	int       test_count = 0;
	int       error_count = 0;

	// Bit by bit shift and XOR over the full operands
	function automatic product_t schoolbook_clmul(input operand_t x, input operand_t y);
		product_t acc;
		acc = '0;
		for (int i = 0; i < `CLMUL_OPERAND_W; i++) begin
			if (x[i]) begin
				acc = acc ^ (product_t'(y) << i);
			end
		end
		return acc;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			pending = 1'b0;
			holding = 1'b0;
		end else begin
			if (req && !req_q) begin
				a_seen  = a;
				b_seen  = b;
				pending = 1'b1;
				holding = 1'b0;
			end
			if (ack && !ack_q) begin
				test_count++;
				if (!pending) begin
					$display("error at %0t: ack rose without a new request", $time);
					error_count++;
				end
				expected = schoolbook_clmul(a_seen, b_seen);
				if (product !== expected) begin
					$display("mismatch at %0t: test %0d product %h expected %h",
						$time, test_count, product, expected);
					error_count++;
					$display("test %0d: fail", test_count);
				end else begin
					$display("test %0d: pass", test_count);
				end
				pending = 1'b0;
				holding = 1'b1;
			end else if (holding && product !== expected) begin
				// Result must hold until the next request starts
				$display("mismatch at %0t: held product %h expected %h", $time, product, expected);
				error_count++;
				holding = 1'b0;
			end
		end
		req_q = req;
		ack_q = ack;
	end

endmodule

`default_nettype wire

// ==== sim/karatsuba_asserts.sv ====
// Handshake and result stability properties, bound into karatsuba_top
// Latency is counted from the edge where req is first sampled high
`default_nettype none

`include "clmul_params.svh"

module karatsuba_asserts (
	input logic                      clk,
	input logic                      rst,
	input logic                      req,
	input logic                      ack,
	input clmul_types_pkg::product_t product
);

	timeunit 1ns;
	timeprecision 1ps;

	logic        req_q;
	logic [31:0] since_req;

	// Cycles since the last req rise
	always_ff @(posedge clk) begin
		req_q <= req;
		if (req && !req_q) begin
			since_req <= '0;
		end else begin
			since_req <= since_req + 32'd1;
		end
	end

	ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
		else $error("ack high during or right after reset");

	ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
		else $error("ack rose without req");

	// req low on three samples in a row leaves no room for ack
	ack_drops_after_req: assert property (@(posedge clk) disable iff (rst)
		(!req && !$past(req) && !$past(req, 2)) |-> !ack)
		else $error("ack still high two cycles after req fell");

	product_held: assert property (@(posedge clk) disable iff (rst) ack |-> $stable(product))
		else $error("product changed while ack high");

	ack_latency: assert property (@(posedge clk) disable iff (rst)
		$rose(ack) |-> (since_req == 32'(`CLMUL_HALF_W + 3)))
		else $error("ack latency differs from CLMUL_HALF_W + 3 cycles");

endmodule

bind karatsuba_top karatsuba_asserts karatsuba_asserts_inst (
	.clk     (clk),
	.rst     (rst),
	.req     (req),
	.ack     (ack),
	.product (product)
);

`default_nettype wire

// ==== logic/karatsuba_top.sv ====
// One-level two-way Karatsuba carry-less multiplier
// Three serial half multipliers run in parallel, latency req to ack is CLMUL_HALF_W + 3
// a and b must stay stable from req rise until ack rise
`default_nettype none

`include "clmul_params.svh"

module karatsuba_top (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      req,
	input  clmul_types_pkg::operand_t a,
	input  clmul_types_pkg::operand_t b,
	output logic                      ack,
	output clmul_types_pkg::product_t product
);

	import clmul_types_pkg::*;

	logic load;
	logic step;
	logic capture;
	logic last;

	half_t a_hi;
	half_t a_lo;
	half_t b_hi;
	half_t b_lo;
	half_t a_sum;
	half_t b_sum;

	partial_t p_high;
	partial_t p_low;
	partial_t p_mid;

	// Operand halves and half sums
	assign a_hi  = a[`CLMUL_HALF_W +: `CLMUL_HALF_W];
	assign a_lo  = a[0 +: `CLMUL_HALF_W];
	assign b_hi  = b[`CLMUL_HALF_W +: `CLMUL_HALF_W];
	assign b_lo  = b[0 +: `CLMUL_HALF_W];
	assign a_sum = a_hi ^ a_lo;
	assign b_sum = b_hi ^ b_lo;

	karatsuba_ctrl karatsuba_ctrl_inst (
		.clk     (clk),
		.rst     (rst),
		.req     (req),
		.last    (last),
		.ack     (ack),
		.load    (load),
		.step    (step),
		.capture (capture)
	);

	bit_counter bit_counter_inst (
		.clk  (clk),
		.rst  (rst),
		.load (load),
		.step (step),
		.last (last)
	);

	clmul_serial clmul_high_inst (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.step    (step),
		.x       (a_hi),
		.y       (b_hi),
		.partial (p_high)
	);

	clmul_serial clmul_low_inst (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.step    (step),
		.x       (a_lo),
		.y       (b_lo),
		.partial (p_low)
	);

	clmul_serial clmul_mid_inst (
		.clk     (clk),
		.rst     (rst),
		.load    (load),
		.step    (step),
		.x       (a_sum),
		.y       (b_sum),
		.partial (p_mid)
	);

	karatsuba_combine karatsuba_combine_inst (
		.clk     (clk),
		.rst     (rst),
		.capture (capture),
		.p_high  (p_high),
		.p_low   (p_low),
		.p_mid   (p_mid),
		.product (product)
	);

endmodule

`default_nettype wire

// ==== logic/karatsuba_combine.sv ====
// Karatsuba recombination of the three half products
// Middle term is p_mid ^ p_high ^ p_low, no carries anywhere
// product updates only on capture and holds otherwise
`default_nettype none

`include "clmul_params.svh"

module karatsuba_combine (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      capture,
	input  clmul_types_pkg::partial_t p_high,
	input  clmul_types_pkg::partial_t p_low,
	input  clmul_types_pkg::partial_t p_mid,
	output clmul_types_pkg::product_t product
);

	import clmul_types_pkg::*;

	partial_t mid_term;
	product_t merged;

	assign mid_term = p_mid ^ p_high ^ p_low;

	// High at the top, middle term one half up, low at the bottom
	assign merged = (product_t'(p_high) << `CLMUL_OPERAND_W)
		^ (product_t'(mid_term) << `CLMUL_HALF_W)
		^ product_t'(p_low);

	always_ff @(posedge clk) begin
		if (rst) begin
			product <= '0;
		end else if (capture) begin
			product <= merged;
		end
	end

endmodule

`default_nettype wire

// ==== logic/clmul_serial.sv ====
// Serial shift-and-xor carry-less multiplier, one bit of x per step
// partial is valid after CLMUL_HALF_W steps and holds until the next load
`default_nettype none

module clmul_serial (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      load,
	input  logic                      step,
	input  clmul_types_pkg::half_t    x,
	input  clmul_types_pkg::half_t    y,
	output clmul_types_pkg::partial_t partial
);

	import clmul_types_pkg::*;

	half_t    x_sr;
	partial_t y_sr;
	partial_t acc;

	// Operand shift registers
	always_ff @(posedge clk) begin
		if (load) begin
			x_sr <= x;
			y_sr <= partial_t'(y);
		end else if (step) begin
			x_sr <= x_sr >> 1;
			y_sr <= y_sr << 1;
		end
	end

	// Accumulator, XOR replaces addition in GF(2)
	always_ff @(posedge clk) begin
		if (rst || load) begin
			acc <= '0;
		end else if (step && x_sr[0]) begin
			acc <= acc ^ y_sr;
		end
	end

	assign partial = acc;

endmodule

`default_nettype wire

// ==== logic/bit_counter.sv ====
// Serial step counter, one count per operand bit of a half
// last is combinational and only meaningful while step is high
`default_nettype none

`include "clmul_params.svh"

module bit_counter (
	input  logic clk,
	input  logic rst,
	input  logic load,
	input  logic step,
	output logic last
);

	import clmul_ctrl_pkg::*;

	count_t count;

	always_ff @(posedge clk) begin
		if (rst || load) begin
			count <= '0;
		end else if (step) begin
			count <= count + 1'b1;
		end
	end

	// Final step of the half-width operand
	assign last = (count == count_t'(`CLMUL_HALF_W - 1));

endmodule

`default_nettype wire

// ==== logic/karatsuba_ctrl.sv ====
// Four-phase req/ack controller for one multiplication at a time
// req must stay high until ack rises, and rise again only after ack falls
// All outputs are registered
`default_nettype none

module karatsuba_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req,
	input  logic last,
	output logic ack,
	output logic load,
	output logic step,
	output logic capture
);

	import clmul_ctrl_pkg::*;

	ctrl_state_t state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= st_idle;
			ack     <= 1'b0;
			load    <= 1'b0;
			step    <= 1'b0;
			capture <= 1'b0;
		end else begin
			// Load and capture are single-cycle pulses
			load    <= 1'b0;
			capture <= 1'b0;

			case (state)
				st_idle: begin
					if (req) begin
						load  <= 1'b1;
						state <= st_run;
					end
				end

				st_run: begin
					// First cycle here is the load cycle, stepping starts after it
					if (step && last) begin
						step    <= 1'b0;
						capture <= 1'b1;
						state   <= st_capture;
					end else begin
						step <= 1'b1;
					end
				end

				st_capture: begin
					state <= st_done;
				end

				st_done: begin
					// Hold ack for as long as the requester keeps req high
					if (req) begin
						ack <= 1'b1;
					end else begin
						ack   <= 1'b0;
						state <= st_idle;
					end
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/clmul_ctrl_pkg.sv ====
// Controller types, state encoding and serial step count
`default_nettype none

`include "clmul_params.svh"

package clmul_ctrl_pkg;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_capture,
		st_done
	} ctrl_state_t;

	// Holds 0 to CLMUL_HALF_W inclusive
	typedef logic [$clog2(`CLMUL_HALF_W + 1)-1:0] count_t;

endpackage

`default_nettype wire

// ==== logic/clmul_types_pkg.sv ====
// Data types for the carry-less multiplier datapath
// All widths come from the macros in clmul_params.svh
`default_nettype none

`include "clmul_params.svh"

package clmul_types_pkg;

	// One full input operand
	typedef logic [`CLMUL_OPERAND_W-1:0] operand_t;

	// One half of an operand, or the XOR of both halves
	typedef logic [`CLMUL_HALF_W-1:0] half_t;

	// Carry-less product of two halves, degree stays below the operand width
	typedef logic [`CLMUL_OPERAND_W-1:0] partial_t;

	// Full carry-less product
	typedef logic [`CLMUL_PRODUCT_W-1:0] product_t;

endpackage

`default_nettype wire

// ==== logic/clmul_params.svh ====
// Width macros for the carry-less Karatsuba multiplier
// CLMUL_OPERAND_W must stay even, the halves are split exactly in two
// Half and product widths follow from the operand width
`ifndef CLMUL_PARAMS_SVH
`define CLMUL_PARAMS_SVH

// Full operand width in bits
`define CLMUL_OPERAND_W 192

// One Karatsuba half of an operand
`define CLMUL_HALF_W (`CLMUL_OPERAND_W / 2)

// Full carry-less product width
`define CLMUL_PRODUCT_W (2 * `CLMUL_OPERAND_W)

`endif
